// ==== design/im2col_addr_calc.sv ====
module im2col_addr_calc
  import im2col_cfg_pkg::*;
  import im2col_desc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  im2col_cfg_t cfg_i,
  im2col_pos_if.calc  pos,
  input  logic        advance_i,
  output addr_res_t   addr_o
);

  logic [31:0] row_d, col_d, index_d;
  logic [31:0] row_q, col_q, index_q;
  logic [31:0] out_ptr_q;
  logic [31:0] out_inc;

  // signed, negative rows and cols land in the padding
  assign row_d = {16'h0, pos.win.h_offset} - {26'h0, cfg_i.pad_top};
  assign col_d = {16'h0, pos.win.w_offset} - {26'h0, cfg_i.pad_left};

  assign index_d = (({24'h0, pos.win.batch_idx} * {24'h0, cfg_i.num_ch} + pos.win.im_c)
                    * cfg_i.ih + row_d) * cfg_i.iw + col_d;

  // one output row per descriptor
  assign out_inc = {16'h0, cfg_i.n_patches_h} * {16'h0, cfg_i.n_patches_w} * ELEM_BYTES;

  always_ff @(posedge clk_i) begin
    if (pos.capture) begin
      row_q   <= row_d;
      col_q   <= col_d;
      index_q <= index_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ptr_q <= '0;
    end else if (pos.start) begin
      out_ptr_q <= cfg_i.dst_ptr;
    end else if (advance_i) begin
      out_ptr_q <= out_ptr_q + out_inc;
    end
  end

  assign addr_o.raw_index  = index_q;
  assign addr_o.output_ptr = out_ptr_q;
  assign addr_o.im_row     = row_q;
  assign addr_o.im_col     = col_q;

endmodule

// ==== design/im2col_cfg_pkg.sv ====
package im2col_cfg_pkg;

  // field widths of the layer configuration
  localparam int unsigned WORD_W  = 32;  // pointers, image sizes, adapted padding
  localparam int unsigned FILT_W  = 8;   // filter dims, channels, batch, strides
  localparam int unsigned COL_W   = 16;  // ch_col
  localparam int unsigned PAD_W   = 6;   // the four plain padding amounts
  localparam int unsigned PATCH_W = 16;  // output patch counts

  // bytes per tensor element
  localparam int unsigned ELEM_BYTES = 4;

  typedef struct packed {
    logic [WORD_W-1:0]  src_ptr;
    logic [WORD_W-1:0]  dst_ptr;
    logic [WORD_W-1:0]  ih;
    logic [WORD_W-1:0]  iw;
    logic [FILT_W-1:0]  fh;
    logic [FILT_W-1:0]  fw;
    logic [FILT_W-1:0]  num_ch;
    logic [FILT_W-1:0]  batch;
    logic [COL_W-1:0]   ch_col;       // num_ch * fh * fw
    logic [PAD_W-1:0]   pad_top;
    logic [PAD_W-1:0]   pad_bottom;
    logic [PAD_W-1:0]   pad_left;
    logic [PAD_W-1:0]   pad_right;
    logic [WORD_W-1:0]  adpt_pad_right;
    logic [WORD_W-1:0]  adpt_pad_bottom;
    logic [FILT_W-1:0]  stride_d1;    // horizontal
    logic [FILT_W-1:0]  stride_d2;    // vertical
    logic [PATCH_W-1:0] n_patches_h;
    logic [PATCH_W-1:0] n_patches_w;
  } im2col_cfg_t;

endpackage

// ==== design/im2col_desc_build.sv ====
module im2col_desc_build
  import im2col_cfg_pkg::*;
  import im2col_desc_pkg::*;
(
  input  im2col_cfg_t cfg_i,
  input  pad_res_t    pad_i,
  input  addr_res_t   addr_i,
  output dma_desc_t   desc_o
);

  logic [31:0] size_d1, size_d2;
  logic [31:0] skip_rows;  // elements skipped by the top zeros
  logic [31:0] skip_cols;  // elements skipped by the left zeros
  logic [31:0] row_pitch;  // stride_d2 * iw
  logic [31:0] index;

  assign size_d1 = {16'h0, cfg_i.n_patches_w} - pad_i.n_zeros_left - pad_i.n_zeros_right;
  assign size_d2 = {16'h0, cfg_i.n_patches_h} - pad_i.n_zeros_top - pad_i.n_zeros_bottom;

  assign row_pitch = {24'h0, cfg_i.stride_d2} * cfg_i.iw;
  assign skip_rows = pad_i.n_zeros_top * row_pitch;
  assign skip_cols = pad_i.n_zeros_left * {24'h0, cfg_i.stride_d1};

  // first element actually read from the image
  assign index = addr_i.raw_index + skip_rows + skip_cols;

  assign desc_o.input_ptr  = cfg_i.src_ptr + index * ELEM_BYTES;
  assign desc_o.output_ptr = addr_i.output_ptr;

  // jump from the last read element of a row to the first of the next
  assign desc_o.in_inc_d2 = row_pitch - {24'h0, cfg_i.stride_d1} * (size_d1 - 32'd1) - 32'd1;

  assign desc_o.n_zeros_top    = pad_i.n_zeros_top;
  assign desc_o.n_zeros_bottom = pad_i.n_zeros_bottom;
  assign desc_o.n_zeros_left   = pad_i.n_zeros_left;
  assign desc_o.n_zeros_right  = pad_i.n_zeros_right;
  assign desc_o.size_d1        = size_d1;
  assign desc_o.size_d2        = size_d2;

endmodule

// ==== design/im2col_desc_fifo.sv ====
module im2col_desc_fifo
  import im2col_desc_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4  // power of two, 2 or more
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  dma_desc_t desc_i,
  input  logic      pop_i,
  output dma_desc_t desc_o,
  output logic      full_o,
  output logic      empty_o
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  dma_desc_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;  // wrap on their own
  logic [PTR_W:0]   count_q;
  logic             do_push, do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;  // pop on empty is dropped

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= desc_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push != do_pop) begin
        count_q <= do_push ? count_q + 1'b1 : count_q - 1'b1;
      end
    end
  end

  assign desc_o  = mem[rd_ptr_q];  // head always visible
  assign full_o  = count_q == (PTR_W+1)'(FIFO_DEPTH);
  assign empty_o = count_q == '0;

endmodule

// ==== design/im2col_desc_pkg.sv ====
package im2col_desc_pkg;

  // filter window position plus the batch image it is computed for
  typedef struct packed {
    logic [15:0] w_offset;
    logic [15:0] h_offset;
    logic [31:0] im_c;
    logic [7:0]  batch_idx;
  } im2col_pos_t;

  typedef struct packed {
    logic [31:0] n_zeros_top;
    logic [31:0] n_zeros_bottom;
    logic [31:0] n_zeros_left;
    logic [31:0] n_zeros_right;
  } pad_res_t;

  // im_row and im_col may go negative inside the padding
  typedef struct packed {
    logic [31:0] raw_index;
    logic [31:0] output_ptr;
    logic [31:0] im_row;
    logic [31:0] im_col;
  } addr_res_t;

  typedef struct packed {
    logic [31:0] input_ptr;
    logic [31:0] output_ptr;
    logic [31:0] in_inc_d2;
    logic [31:0] n_zeros_top;
    logic [31:0] n_zeros_bottom;
    logic [31:0] n_zeros_left;
    logic [31:0] n_zeros_right;
    logic [31:0] size_d1;
    logic [31:0] size_d2;
  } dma_desc_t;

endpackage

// ==== design/im2col_pad_calc.sv ====
module im2col_pad_calc
  import im2col_cfg_pkg::*;
  import im2col_desc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  im2col_cfg_t cfg_i,
  im2col_pos_if.calc  pos,
  output pad_res_t    pad_o
);

  pad_res_t    pad_d;
  logic [31:0] fw_rem;  // fw - 1 - w_offset
  logic [31:0] fh_rem;  // fh - 1 - h_offset
  logic [31:0] top_gap, left_gap;

  // division rounded up, stride is never zero
  function automatic logic [31:0] ceil_div(input logic [31:0] num, input logic [7:0] den);
    ceil_div = (num + {24'h0, den} - 32'd1) / {24'h0, den};
  endfunction

  assign fw_rem   = {24'h0, cfg_i.fw} - 32'd1 - {16'h0, pos.win.w_offset};
  assign fh_rem   = {24'h0, cfg_i.fh} - 32'd1 - {16'h0, pos.win.h_offset};
  assign top_gap  = {26'h0, cfg_i.pad_top} - {16'h0, pos.win.h_offset};
  assign left_gap = {26'h0, cfg_i.pad_left} - {16'h0, pos.win.w_offset};

  always_comb begin
    // top and left, window still inside the leading pad
    if (pos.win.h_offset >= {10'h0, cfg_i.pad_top}) begin
      pad_d.n_zeros_top = '0;
    end else begin
      pad_d.n_zeros_top = ceil_div(top_gap, cfg_i.stride_d2);
    end

    if (pos.win.w_offset >= {10'h0, cfg_i.pad_left}) begin
      pad_d.n_zeros_left = '0;
    end else begin
      pad_d.n_zeros_left = ceil_div(left_gap, cfg_i.stride_d1);
    end

    // right and bottom go against the adapted padding
    if (fw_rem >= {26'h0, cfg_i.pad_right} || cfg_i.adpt_pad_right == '0) begin
      pad_d.n_zeros_right = '0;
    end else begin
      pad_d.n_zeros_right = ceil_div(cfg_i.adpt_pad_right - fw_rem, cfg_i.stride_d1);
    end

    if (fh_rem >= {26'h0, cfg_i.pad_bottom} || cfg_i.adpt_pad_bottom == '0) begin
      pad_d.n_zeros_bottom = '0;
    end else begin
      pad_d.n_zeros_bottom = ceil_div(cfg_i.adpt_pad_bottom - fh_rem, cfg_i.stride_d2);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pad_o <= '0;
    end else if (pos.start) begin
      pad_o <= '0;
    end else if (pos.capture) begin
      pad_o <= pad_d;
    end
  end

endmodule

// ==== design/im2col_param_seq.sv ====
module im2col_param_seq
  import im2col_cfg_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  im2col_cfg_t cfg_i,
  input  logic        start_i,
  input  logic        ack_i,
  input  logic        fifo_full_i,
  output logic        push_o,
  output logic        advance_o,
  output logic        done_o,
  im2col_pos_if.seq   pos
);

  typedef enum logic [2:0] {IDLE, ZEROS, PUSH, OUT_UPDATE, OFFSET_UPDATE} state_e;

  state_e      state_q, state_d;
  logic [15:0] w_offset_q;
  logic [15:0] h_offset_q;
  logic [31:0] im_c_q;
  logic [15:0] ch_col_cnt_q;
  logic [7:0]  batch_cnt_q;
  logic        done_q;
  logic        start_acc;
  logic        w_last, h_last, batch_last, group_last;

  assign start_acc  = start_i && (state_q == IDLE);  // ignored mid-run
  assign w_last     = w_offset_q == {8'h0, cfg_i.fw} - 16'd1;
  assign h_last     = h_offset_q == {8'h0, cfg_i.fh} - 16'd1;
  assign batch_last = batch_cnt_q == cfg_i.batch - 8'd1;
  assign group_last = ch_col_cnt_q == cfg_i.ch_col - 16'd1;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_acc) state_d = ZEROS;
      end
      ZEROS: begin
        if (!fifo_full_i) state_d = PUSH;  // hold and recapture while full
      end
      PUSH:       state_d = OUT_UPDATE;
      OUT_UPDATE: state_d = batch_last ? OFFSET_UPDATE : ZEROS;
      OFFSET_UPDATE: begin
        state_d = group_last ? IDLE : ZEROS;
      end
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // loop counters, innermost is the batch
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_offset_q   <= '0;
      h_offset_q   <= '0;
      im_c_q       <= '0;
      ch_col_cnt_q <= '0;
      batch_cnt_q  <= '0;
    end else if (start_acc) begin
      w_offset_q   <= '0;
      h_offset_q   <= '0;
      im_c_q       <= '0;
      ch_col_cnt_q <= '0;
      batch_cnt_q  <= '0;
    end else if (state_q == OUT_UPDATE) begin
      batch_cnt_q <= batch_cnt_q + 8'd1;
    end else if (state_q == OFFSET_UPDATE) begin
      batch_cnt_q  <= '0;
      w_offset_q   <= w_last ? '0 : w_offset_q + 16'd1;
      ch_col_cnt_q <= group_last ? '0 : ch_col_cnt_q + 16'd1;
      if (w_last) begin
        h_offset_q <= h_last ? '0 : h_offset_q + 16'd1;
      end
      if (w_last && h_last) begin
        im_c_q <= im_c_q + 32'd1;  // next channel
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (start_acc || ack_i) begin
      done_q <= 1'b0;
    end else if (state_q == OFFSET_UPDATE && group_last) begin
      done_q <= 1'b1;
    end
  end

  assign pos.win = '{w_offset: w_offset_q, h_offset: h_offset_q,
                     im_c: im_c_q, batch_idx: batch_cnt_q};
  assign pos.capture = state_q == ZEROS;
  assign pos.start   = start_acc;

  assign push_o    = state_q == PUSH;
  assign advance_o = state_q == OUT_UPDATE;
  assign done_o    = done_q;

endmodule

// ==== design/im2col_param_top.sv ====
module im2col_param_top
  import im2col_cfg_pkg::*;
  import im2col_desc_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [WORD_W-1:0]  src_ptr_i,
  input  logic [WORD_W-1:0]  dst_ptr_i,
  input  logic [WORD_W-1:0]  ih_i,
  input  logic [WORD_W-1:0]  iw_i,
  input  logic [FILT_W-1:0]  fh_i,
  input  logic [FILT_W-1:0]  fw_i,
  input  logic [FILT_W-1:0]  num_ch_i,
  input  logic [FILT_W-1:0]  batch_i,
  input  logic [COL_W-1:0]   ch_col_i,
  input  logic [PAD_W-1:0]   pad_top_i,
  input  logic [PAD_W-1:0]   pad_bottom_i,
  input  logic [PAD_W-1:0]   pad_left_i,
  input  logic [PAD_W-1:0]   pad_right_i,
  input  logic [WORD_W-1:0]  adpt_pad_right_i,
  input  logic [WORD_W-1:0]  adpt_pad_bottom_i,
  input  logic [FILT_W-1:0]  stride_d1_i,
  input  logic [FILT_W-1:0]  stride_d2_i,
  input  logic [PATCH_W-1:0] n_patches_h_i,
  input  logic [PATCH_W-1:0] n_patches_w_i,
  input  logic               start_i,
  input  logic               ack_i,
  input  logic               desc_pop_i,
  output logic               done_o,
  output logic               desc_empty_o,
  output logic [31:0]        input_ptr_o,
  output logic [31:0]        output_ptr_o,
  output logic [31:0]        in_inc_d2_o,
  output logic [31:0]        n_zeros_top_o,
  output logic [31:0]        n_zeros_bottom_o,
  output logic [31:0]        n_zeros_left_o,
  output logic [31:0]        n_zeros_right_o,
  output logic [31:0]        size_d1_o,
  output logic [31:0]        size_d2_o
);

  im2col_cfg_t cfg;
  pad_res_t    pad;
  addr_res_t   addr;
  dma_desc_t   desc_in, desc_head;
  logic        push, advance, fifo_full;

  im2col_pos_if pos_if ();

  assign cfg = '{src_ptr: src_ptr_i, dst_ptr: dst_ptr_i, ih: ih_i, iw: iw_i,
                 fh: fh_i, fw: fw_i, num_ch: num_ch_i, batch: batch_i, ch_col: ch_col_i,
                 pad_top: pad_top_i, pad_bottom: pad_bottom_i,
                 pad_left: pad_left_i, pad_right: pad_right_i,
                 adpt_pad_right: adpt_pad_right_i, adpt_pad_bottom: adpt_pad_bottom_i,
                 stride_d1: stride_d1_i, stride_d2: stride_d2_i,
                 n_patches_h: n_patches_h_i, n_patches_w: n_patches_w_i};

  im2col_param_seq u_seq (
    .clk_i, .rst_ni, .cfg_i(cfg), .start_i, .ack_i, .fifo_full_i(fifo_full),
    .push_o(push), .advance_o(advance), .done_o, .pos(pos_if)
  );

  im2col_pad_calc u_pad (.clk_i, .rst_ni, .cfg_i(cfg), .pos(pos_if), .pad_o(pad));

  im2col_addr_calc u_addr (
    .clk_i, .rst_ni, .cfg_i(cfg), .pos(pos_if), .advance_i(advance), .addr_o(addr)
  );

  im2col_desc_build u_build (.cfg_i(cfg), .pad_i(pad), .addr_i(addr), .desc_o(desc_in));

  im2col_desc_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk_i, .rst_ni, .push_i(push), .desc_i(desc_in), .pop_i(desc_pop_i),
    .desc_o(desc_head), .full_o(fifo_full), .empty_o(desc_empty_o)
  );

  // fifo head out to the dma side
  assign input_ptr_o      = desc_head.input_ptr;
  assign output_ptr_o     = desc_head.output_ptr;
  assign in_inc_d2_o      = desc_head.in_inc_d2;
  assign n_zeros_top_o    = desc_head.n_zeros_top;
  assign n_zeros_bottom_o = desc_head.n_zeros_bottom;
  assign n_zeros_left_o   = desc_head.n_zeros_left;
  assign n_zeros_right_o  = desc_head.n_zeros_right;
  assign size_d1_o        = desc_head.size_d1;
  assign size_d2_o        = desc_head.size_d2;

endmodule

// ==== design/im2col_pos_if.sv ====
interface im2col_pos_if
  import im2col_desc_pkg::*;
();

  im2col_pos_t win;      // position under computation
  logic        capture;  // calculators register on this edge
  logic        start;    // accepted start of a new layer

  modport seq (
    output win,
    output capture,
    output start
  );

  modport calc (
    input win,
    input capture,
    input start
  );

endinterface

// ==== dv/im2col_checker.sv ====
module im2col_checker
  import im2col_cfg_pkg::*;
  import im2col_desc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  im2col_cfg_t cfg_i,
  input  logic        start_i,
  input  logic        ack_i,
  input  logic        pop_i,
  input  logic        empty_i,
  input  logic        done_i,
  input  dma_desc_t   head_i,
  output logic        drained_o,
  output int          err_cnt_o,
  output int          test_cnt_o,
  output int          check_cnt_o
);
  timeunit 1ns;
  timeprecision 100ps;

  dma_desc_t exp_q[$];  // descriptors still owed by the DUT in order
  logic      busy;
  logic      ack_seen;
  logic      done_flagged;
  logic      reset_reported;
  int        test_idx;
  int        test_errs;
  int        desc_idx;
  int        reset_edges;

  assign drained_o = !busy;

  function automatic int unsigned up_div(input int unsigned num, input int unsigned den);
    return num / den + ((num % den != 0) ? 32'd1 : 32'd0);
  endfunction

  // reference descriptor k of the run for window group grp and batch image b
  function automatic dma_desc_t expect_desc(input im2col_cfg_t c, input int unsigned grp,
                                            input int unsigned b, input int unsigned k);
    int unsigned w, h, ch, fw, fh, s1, s2, w_rem, h_rem;
    logic [31:0] top, bot, lft, rgt, idx;
    dma_desc_t   d;
    fw = 32'(c.fw);
    fh = 32'(c.fh);
    s1 = 32'(c.stride_d1);
    s2 = 32'(c.stride_d2);
    w  = grp % fw;  // window column moves fastest
    h  = (grp / fw) % fh;
    ch = grp / (fw * fh);
    w_rem = fw - 1 - w;
    h_rem = fh - 1 - h;
    top = (h < 32'(c.pad_top)) ? up_div(32'(c.pad_top) - h, s2) : 32'd0;
    lft = (w < 32'(c.pad_left)) ? up_div(32'(c.pad_left) - w, s1) : 32'd0;
    rgt = 32'd0;
    bot = 32'd0;
    if (w_rem < 32'(c.pad_right) && c.adpt_pad_right != 0) begin
      rgt = up_div(c.adpt_pad_right - w_rem, s1);
    end
    if (h_rem < 32'(c.pad_bottom) && c.adpt_pad_bottom != 0) begin
      bot = up_div(c.adpt_pad_bottom - h_rem, s2);
    end
    // row and col wrap below zero inside the padding
    idx = (b * 32'(c.num_ch) + ch) * c.ih;
    idx = (idx + h - 32'(c.pad_top)) * c.iw + w - 32'(c.pad_left);
    idx = idx + top * s2 * c.iw + lft * s1;  // skip the zero rows and cols
    d.input_ptr      = c.src_ptr + idx * ELEM_BYTES;
    d.output_ptr     = c.dst_ptr + k * 32'(c.n_patches_h) * 32'(c.n_patches_w) * ELEM_BYTES;
    d.n_zeros_top    = top;
    d.n_zeros_bottom = bot;
    d.n_zeros_left   = lft;
    d.n_zeros_right  = rgt;
    d.size_d1        = 32'(c.n_patches_w) - lft - rgt;
    d.size_d2        = 32'(c.n_patches_h) - top - bot;
    d.in_inc_d2      = s2 * c.iw - s1 * (d.size_d1 - 1) - 1;
    return d;
  endfunction

  task automatic report_fault(input string msg);
    $display("ERR %0t: test %0d: %s", $time, test_idx, msg);
    test_errs++;
    err_cnt_o++;
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt_o++;
    if (got !== exp) begin
      $display("ERR %0t: test %0d desc %0d %s is %08h, expected %08h",
               $time, test_idx, desc_idx, name, got, exp);
      test_errs++;
      err_cnt_o++;
    end
  endtask

  task automatic load_model();
    int unsigned g, b, nb;
    nb = 32'(cfg_i.batch);
    exp_q.delete();
    for (g = 0; g < 32'(cfg_i.ch_col); g++) begin
      for (b = 0; b < nb; b++) begin
        exp_q.push_back(expect_desc(cfg_i, g, b, g * nb + b));
      end
    end
    test_idx++;
    test_errs    = 0;
    desc_idx     = 0;
    done_flagged = 1'b0;
    busy         = 1'b1;
  endtask

  task automatic compare_head();
    dma_desc_t e;
    if (exp_q.size() == 0) begin
      report_fault("a descriptor was popped that the model does not expect");
      return;
    end
    e = exp_q.pop_front();
    check_field("input_ptr", head_i.input_ptr, e.input_ptr);
    check_field("output_ptr", head_i.output_ptr, e.output_ptr);
    check_field("in_inc_d2", head_i.in_inc_d2, e.in_inc_d2);
    check_field("n_zeros_top", head_i.n_zeros_top, e.n_zeros_top);
    check_field("n_zeros_bottom", head_i.n_zeros_bottom, e.n_zeros_bottom);
    check_field("n_zeros_left", head_i.n_zeros_left, e.n_zeros_left);
    check_field("n_zeros_right", head_i.n_zeros_right, e.n_zeros_right);
    check_field("size_d1", head_i.size_d1, e.size_d1);
    check_field("size_d2", head_i.size_d2, e.size_d2);
    desc_idx++;
    if (exp_q.size() == 0) begin
      $display("test %0d: %0d descriptors, %0d errors", test_idx, desc_idx, test_errs);
      test_cnt_o++;
      busy = 1'b0;
    end
  endtask

  initial begin
    busy           = 1'b0;
    ack_seen       = 1'b0;
    done_flagged   = 1'b0;
    reset_reported = 1'b0;
    test_idx       = 0;
    test_errs      = 0;
    desc_idx       = 0;
    reset_edges    = 0;
    err_cnt_o      = 0;
    test_cnt_o     = 0;
    check_cnt_o    = 0;
  end

  // sampled on the rising edge while inputs move on the falling one
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      if (reset_edges > 0) begin  // first edge may still see unknowns
        check_cnt_o++;
        if (done_i !== 1'b0 || empty_i !== 1'b1) begin
          $display("ERR %0t: in reset done_o is %b and desc_empty_o is %b",
                   $time, done_i, empty_i);
          test_errs++;
          err_cnt_o++;
        end
      end
      reset_edges++;
    end else begin
      if (!reset_reported) begin
        $display("test 0: reset state, %0d errors", test_errs);
        test_cnt_o++;
        reset_reported = 1'b1;
      end
      if (ack_seen && done_i) begin
        report_fault("done_o stayed high after ack_i");
      end
      // once done all owed descriptors must already sit in the FIFO
      if (done_i && !done_flagged && exp_q.size() != 0 && empty_i) begin
        report_fault("done_o rose before the last descriptor was pushed");
        done_flagged = 1'b1;
      end
      if (done_i && exp_q.size() == 0 && !empty_i) begin
        report_fault("the FIFO still holds a descriptor after the last expected one");
      end
      if (pop_i && !empty_i) begin
        compare_head();
      end
      if (start_i && !busy) begin
        load_model();
      end
      ack_seen = ack_i;
    end
  end

endmodule

// ==== dv/tb_im2col.sv ====
module tb_im2col
  import im2col_cfg_pkg::*;
  import im2col_desc_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned CLK_PERIOD   = 20;
  localparam int unsigned NUM_TESTS    = 30;
  localparam int unsigned FIFO_DEPTH   = 4;
  localparam int unsigned MAX_DESC     = 27 * 3;  // largest ch_col times largest batch
  localparam int unsigned LIMIT_CYCLES = NUM_TESTS * (MAX_DESC * 4 + 2000);

  logic        clk_i;
  logic        rst_ni;
  logic        start_i;
  logic        ack_i;
  logic        desc_pop_i;
  logic        pop_en;
  logic        done_o;
  logic        desc_empty_o;
  logic        drained;
  im2col_cfg_t cfg;
  dma_desc_t   head;
  int          err_cnt;
  int          test_cnt;
  int          check_cnt;

  im2col_param_top #(.FIFO_DEPTH(FIFO_DEPTH)) i_im2col_param_top (
    .clk_i, .rst_ni,
    .src_ptr_i(cfg.src_ptr), .dst_ptr_i(cfg.dst_ptr), .ih_i(cfg.ih), .iw_i(cfg.iw),
    .fh_i(cfg.fh), .fw_i(cfg.fw), .num_ch_i(cfg.num_ch), .batch_i(cfg.batch),
    .ch_col_i(cfg.ch_col), .pad_top_i(cfg.pad_top), .pad_bottom_i(cfg.pad_bottom),
    .pad_left_i(cfg.pad_left), .pad_right_i(cfg.pad_right),
    .adpt_pad_right_i(cfg.adpt_pad_right), .adpt_pad_bottom_i(cfg.adpt_pad_bottom),
    .stride_d1_i(cfg.stride_d1), .stride_d2_i(cfg.stride_d2),
    .n_patches_h_i(cfg.n_patches_h), .n_patches_w_i(cfg.n_patches_w),
    .start_i, .ack_i, .desc_pop_i, .done_o, .desc_empty_o,
    .input_ptr_o(head.input_ptr), .output_ptr_o(head.output_ptr),
    .in_inc_d2_o(head.in_inc_d2), .n_zeros_top_o(head.n_zeros_top),
    .n_zeros_bottom_o(head.n_zeros_bottom), .n_zeros_left_o(head.n_zeros_left),
    .n_zeros_right_o(head.n_zeros_right), .size_d1_o(head.size_d1), .size_d2_o(head.size_d2)
  );

  im2col_checker u_checker (
    .clk_i, .rst_ni, .cfg_i(cfg), .start_i, .ack_i, .pop_i(desc_pop_i),
    .empty_i(desc_empty_o), .done_i(done_o), .head_i(head), .drained_o(drained),
    .err_cnt_o(err_cnt), .test_cnt_o(test_cnt), .check_cnt_o(check_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // dma side pops about every other cycle
  always @(negedge clk_i) begin
    desc_pop_i = pop_en && ($urandom_range(1, 0) == 1);
  end

  task automatic pick_config(input int unsigned t);
    int unsigned kind, fh, fw, nch, nb, s1, s2, pt, pb, pl, pr, ih, iw, ar, ab;
    kind = (t < 4) ? t : 4;  // first four aim at one feature each
    fh   = $urandom_range(3, 1);
    fw   = $urandom_range(3, 1);
    nch  = $urandom_range(3, 1);
    nb   = $urandom_range(3, 1);
    s1   = (kind == 0) ? 1 : $urandom_range(2, 1);
    s2   = (kind == 0) ? 1 : $urandom_range(2, 1);
    pt   = $urandom_range(3, 0);
    pb   = $urandom_range(3, 0);
    pl   = $urandom_range(3, 0);
    pr   = $urandom_range(3, 0);
    ih   = $urandom_range(31, 12);  // large enough to keep sizes positive
    iw   = $urandom_range(31, 12);
    if (kind == 0) begin
      pt = 0;
      pb = 0;
      pl = 0;
      pr = 0;
    end else if (kind == 1) begin
      pt = $urandom_range(3, 1);
      pl = $urandom_range(3, 1);
      pb = 0;
      pr = 0;
    end else if (kind < 4) begin
      pt = 0;
      pl = 0;
      pb = $urandom_range(3, 1);
      pr = $urandom_range(3, 1);
    end
    ar = ($urandom_range(1, 0) == 1) ? pr : 0;
    ab = ($urandom_range(1, 0) == 1) ? pb : 0;
    if (kind == 2) begin
      ar = 0;
      ab = 0;
    end else if (kind == 3) begin
      ar = pr;
      ab = pb;
    end
    cfg.src_ptr         = $urandom & 32'hffff_fffc;  // word aligned
    cfg.dst_ptr         = $urandom & 32'hffff_fffc;
    cfg.ih              = ih;
    cfg.iw              = iw;
    cfg.fh              = 8'(fh);
    cfg.fw              = 8'(fw);
    cfg.num_ch          = 8'(nch);
    cfg.batch           = 8'(nb);
    cfg.ch_col          = 16'(nch * fh * fw);
    cfg.pad_top         = 6'(pt);
    cfg.pad_bottom      = 6'(pb);
    cfg.pad_left        = 6'(pl);
    cfg.pad_right       = 6'(pr);
    cfg.adpt_pad_right  = ar;
    cfg.adpt_pad_bottom = ab;
    cfg.stride_d1       = 8'(s1);
    cfg.stride_d2       = 8'(s2);
    cfg.n_patches_h     = 16'((ih + pt + pb - fh) / s2 + 1);
    cfg.n_patches_w     = 16'((iw + pl + pr - fw) / s1 + 1);
  endtask

  task automatic run_test(input int unsigned t);
    pick_config(t);
    @(negedge clk_i);
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    if (t % 5 == 4) begin
      pop_en = 1'b0;  // hold the dma side off so the FIFO fills
      repeat (60) @(negedge clk_i);
    end
    pop_en = 1'b1;
    while (!done_o || !drained) @(negedge clk_i);
    ack_i = 1'b1;
    @(negedge clk_i);
    ack_i = 1'b0;
    repeat (2) @(negedge clk_i);
  endtask

  initial begin
    int unsigned t;
    void'($urandom(32'ha459b39c));
    cfg           = '0;
    cfg.fh        = 8'd1;
    cfg.fw        = 8'd1;
    cfg.stride_d1 = 8'd1;
    cfg.stride_d2 = 8'd1;
    rst_ni        = 1'b0;
    start_i       = 1'b0;
    ack_i         = 1'b0;
    desc_pop_i    = 1'b0;
    pop_en        = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    repeat (5) @(negedge clk_i);
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0 && test_cnt == NUM_TESTS + 1) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog sized for the largest layer in every test
  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run timed out", LIMIT_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_im2col \
  -f verilog.f > build.log 2>&1 &&
  ./obj_dir/Vtb_im2col > sim.log 2>&1 ||
  echo "build or simulation returned an error, see build.log and sim.log"
grep -qx "Regression passed" sim.log && echo "PASS" ||
  { echo "FAIL, see sim.log"; exit 1; }

// ==== verilog.f ====
design/im2col_cfg_pkg.sv
design/im2col_desc_pkg.sv
design/im2col_pos_if.sv
design/im2col_param_seq.sv
design/im2col_pad_calc.sv
design/im2col_addr_calc.sv
design/im2col_desc_build.sv
design/im2col_desc_fifo.sv
design/im2col_param_top.sv
dv/im2col_checker.sv
dv/tb_im2col.sv
